/* mem_complex.f */
mem_map_pkg.sv
link_pkg.sv
credit_fifo.sv
region_decoder.sv
load_port.sv
ddr_load_arbiter.sv
mem_complex.sv
mem_complex_assertions.sv
tb_mem_complex.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal --timescale 1ns/1ps
TOP       ?= tb_mem_complex
FILELIST  ?= mem_complex.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_mem_complex.sv */
module tb_mem_complex import mem_map_pkg::*, link_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned RAND_SEED  = 32'hdf6b88e1;
    localparam int          WAIT_LIMIT = 200;  // cycles any single wait may take

    logic  clk_i   = 1'b0;
    logic  rst_n_i = 1'b0;
    logic  req_valid_i [NUM_PORTS];
    addr_t req_addr_i  [NUM_PORTS];
    logic  rsp_valid_o [NUM_PORTS];
    data_t rsp_data_o  [NUM_PORTS];
    logic  rsp_err_o   [NUM_PORTS];
    logic  ddr_req_valid_o;
    addr_t ddr_req_addr_o;
    logic  ddr_req_instr_o;
    logic  ddr_rsp_valid_i = 1'b0;
    data_t ddr_rsp_data_i  = '0;

    addr_t exp_addr_q [NUM_PORTS][$];  // every address sent, per port
    data_t got_data_q [NUM_PORTS][$];
    logic  got_err_q  [NUM_PORTS][$];
    int    checked_cnt [NUM_PORTS];
    addr_t ddr_log_addr [$];
    logic  ddr_log_instr [$];
    int    ddr_due [$];
    int    ddr_served = 0;
    int    cycle_cnt  = 0;
    logic  ddr_hold   = 1'b0;  // holds back every DDR response while high
    int    checks = 0;
    int    value_errors = 0;
    int    other_errors = 0;

    mem_complex mem_complex_i (.*);

    always #20 clk_i = ~clk_i;

    // ==================================================
    // DDR model and response monitor
    // ==================================================

    initial begin
        logic  fire;
        addr_t rsp_addr;
        void'($urandom(RAND_SEED));
        forever begin
            @(posedge clk_i);
            cycle_cnt++;
            if (ddr_req_valid_o) begin
                ddr_log_addr.push_back(ddr_req_addr_o);
                ddr_log_instr.push_back(ddr_req_instr_o);
                ddr_due.push_back(cycle_cnt + int'($urandom_range(5, 0)));
            end
            fire = !ddr_hold && (ddr_served < ddr_due.size())
                   && (ddr_due[ddr_served] <= cycle_cnt);
            rsp_addr = fire ? ddr_log_addr[ddr_served] : '0;
            if (fire) ddr_served++;  // answers strictly in request order
            #1;
            ddr_rsp_valid_i = fire;
            ddr_rsp_data_i  = fire ? (rsp_addr ^ 32'h5a5a_a5a5) : '0;
        end
    end

    always @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n_i && rsp_valid_o[p]) begin
                got_data_q[p].push_back(rsp_data_o[p]);
                got_err_q[p].push_back(rsp_err_o[p]);
            end
        end
    end

    // ==================================================
    // helpers and compare tasks
    // ==================================================

    function automatic logic expect_err(input addr_t addr);
        return (addr < USER_MEM_START) || (addr >= USER_MEM_END);
    endfunction

    function automatic data_t expect_data(input addr_t addr);
        return expect_err(addr) ? '0 : ((addr - USER_MEM_START) ^ 32'h5a5a_a5a5);
    endfunction

    function automatic int credits_left(input int p);
        return QUEUE_DEPTH - exp_addr_q[p].size() + got_data_q[p].size();
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_valid_i[p] = 1'b0;
        end
    endtask

    // drives one request in the current cycle, the caller then moves on with next_cycle
    task automatic post_req(input int p, input addr_t addr);
        if (credits_left(p) == 0) begin
            other_errors++;
            $display("port %0d has no credit left for address 0x%08h", p, addr);
            return;
        end
        req_valid_i[p] = 1'b1;
        req_addr_i[p]  = addr;
        exp_addr_q[p].push_back(addr);
    endtask

    task automatic wait_ddr_reqs(input int n, output logic ok);
        int waited;
        waited = 0;
        while (ddr_log_addr.size() < n && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        ok = (ddr_log_addr.size() >= n);
        if (!ok) begin
            other_errors++;
            $display("timed out waiting for DDR request number %0d", n);
        end
    endtask

    task automatic collect_responses(input int p);
        int    waited;
        addr_t addr;
        waited = 0;
        while (got_data_q[p].size() < exp_addr_q[p].size() && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (got_data_q[p].size() < exp_addr_q[p].size()) begin
            other_errors++;
            $display("timed out waiting for responses on port %0d", p);
        end
        while (checked_cnt[p] < got_data_q[p].size()
               && checked_cnt[p] < exp_addr_q[p].size()) begin
            addr = exp_addr_q[p][checked_cnt[p]];
            check_bit($sformatf("rsp_err_o[%0d]", p), got_err_q[p][checked_cnt[p]],
                      expect_err(addr));
            check_data($sformatf("rsp_data_o[%0d]", p), got_data_q[p][checked_cnt[p]],
                       expect_data(addr));
            checked_cnt[p]++;
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================

    task automatic idle_after_reset();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            check_bit("rsp_valid_o[0]", rsp_valid_o[0], 1'b0);
            check_bit("rsp_valid_o[1]", rsp_valid_o[1], 1'b0);
            check_bit("ddr_req_valid_o", ddr_req_valid_o, 1'b0);
        end
    endtask

    task automatic single_fetch();
        int   mark;
        logic ok;
        mark = ddr_log_addr.size();
        post_req(int'(PORT_INSTR), USER_MEM_START + 32'd16);
        next_cycle();
        wait_ddr_reqs(mark + 1, ok);
        if (ok) begin
            check_addr("ddr_req_addr_o", ddr_log_addr[mark], 32'd16);
            check_bit("ddr_req_instr_o", ddr_log_instr[mark], 1'b1);
        end
        collect_responses(int'(PORT_INSTR));
    endtask

    task automatic out_of_region();
        int mark;
        mark = ddr_log_addr.size();
        post_req(0, USER_MEM_START - 32'd4);
        post_req(1, USER_MEM_END);
        next_cycle();
        collect_responses(0);
        collect_responses(1);
        repeat (6) next_cycle();  // long enough for a stray DDR request to show
        check_data("ddr request count", data_t'(ddr_log_addr.size()), data_t'(mark));
    endtask

    task automatic same_cycle_priority();
        int   mark;
        logic ok;
        mark = ddr_log_addr.size();
        post_req(0, USER_MEM_START + 32'h100);
        post_req(1, USER_MEM_START + 32'h200);
        next_cycle();
        wait_ddr_reqs(mark + 2, ok);
        if (ok) begin
            check_addr("ddr_req_addr_o", ddr_log_addr[mark], 32'h200);  // data port goes first
            check_bit("ddr_req_instr_o", ddr_log_instr[mark], 1'b0);
            check_addr("ddr_req_addr_o", ddr_log_addr[mark + 1], 32'h100);
            check_bit("ddr_req_instr_o", ddr_log_instr[mark + 1], 1'b1);
        end
        collect_responses(0);
        collect_responses(1);
    endtask

    task automatic in_order_with_error();
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            post_req(0, (i == 2) ? USER_MEM_END + 32'(i * 4)
                                 : USER_MEM_START + 32'h1000 + 32'(i * 4));
            post_req(1, (i == 1) ? USER_MEM_START - 32'h10
                                 : USER_MEM_START + 32'h2000 + 32'(i * 4));
            next_cycle();
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            collect_responses(p);
            check_data($sformatf("credits of port %0d", p), data_t'(credits_left(p)),
                       data_t'(QUEUE_DEPTH));
        end
    endtask

    task automatic credit_stall();
        int   mark;
        logic ok;
        mark = ddr_log_addr.size();
        ddr_hold = 1'b1;
        for (int i = 0; i < 4; i++) begin
            post_req(1, USER_MEM_START + 32'h3000 + 32'(i * 4));
            if (i < 2) post_req(0, USER_MEM_START + 32'h4000 + 32'(i * 4));
            next_cycle();
        end
        wait_ddr_reqs(mark + DDR_CREDITS, ok);
        repeat (10) next_cycle();
        check_data("ddr request count", data_t'(ddr_log_addr.size()),
                   data_t'(mark + DDR_CREDITS));
        ddr_hold = 1'b0;
        wait_ddr_reqs(mark + 6, ok);  // the held loads drain once DDR answers again
        collect_responses(0);
        collect_responses(1);
    endtask

    initial begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_valid_i[p] = 1'b0;
            req_addr_i[p]  = '0;
            checked_cnt[p] = 0;
        end
        repeat (16) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        idle_after_reset();
        single_fetch();
        out_of_region();
        same_cycle_priority();
        in_order_with_error();
        credit_stall();

        $display("%0d checks, %0d value mismatches, %0d other failures",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_mem_complex

/* mem_complex_assertions.sv */
module mem_complex_assertions import link_pkg::*; (
    input logic                               clk_i,
    input logic                               rst_n_i,
    input logic                               head_valid_i [NUM_PORTS],
    input logic                               pop_o        [NUM_PORTS],
    input logic                               ddr_req_valid_o,
    input logic [$clog2(DDR_CREDITS + 1)-1:0] credits_i,
    input logic                               rsp_valid_o  [NUM_PORTS]
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [NUM_PORTS-1:0] rsp_vec;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rsp_vec[p] = rsp_valid_o[p];
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_pop
        pop_needs_head: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            pop_o[p] |-> head_valid_i[p])
            else $error("arbiter popped port %0d while its head was invalid", p);
    end

    // the request pulse trails the issue by one cycle, so look at the credits one edge back
    req_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ddr_req_valid_o |-> ($past(credits_i) != '0))
        else $error("DDR request issued while no DDR credit was held");

    one_rsp_per_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(rsp_vec))
        else $error("more than one response delivered in one cycle");

endmodule : mem_complex_assertions

bind ddr_load_arbiter mem_complex_assertions arbiter_assertions_i (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .head_valid_i    ( head_valid_i    ),
    .pop_o           ( pop_o           ),
    .ddr_req_valid_o ( ddr_req_valid_o ),
    .credits_i       ( ddr_credits     ),
    .rsp_valid_o     ( rsp_valid_o     )
);

/* mem_complex.sv */
module mem_complex import mem_map_pkg::*, link_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // requester side, index 0 is fetch and index 1 is data
    input  logic  req_valid_i [NUM_PORTS],
    input  addr_t req_addr_i  [NUM_PORTS],
    output logic  rsp_valid_o [NUM_PORTS],
    output data_t rsp_data_o  [NUM_PORTS],
    output logic  rsp_err_o   [NUM_PORTS],

    // DDR load channel
    output logic  ddr_req_valid_o,
    output addr_t ddr_req_addr_o,
    output logic  ddr_req_instr_o,
    input  logic  ddr_rsp_valid_i,
    input  data_t ddr_rsp_data_i
);

    logic      fwd_valid  [NUM_PORTS];
    port_req_t fwd_req    [NUM_PORTS];
    logic      head_valid [NUM_PORTS];
    port_req_t head       [NUM_PORTS];
    logic      pop        [NUM_PORTS];

    region_decoder region_decoder_i (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_valid_i ( req_valid_i ),
        .req_addr_i  ( req_addr_i  ),
        .fwd_valid_o ( fwd_valid   ),
        .fwd_req_o   ( fwd_req     )
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        load_port load_port_i (
            .clk_i        ( clk_i         ),
            .rst_n_i      ( rst_n_i       ),
            .push_i       ( fwd_valid[p]  ),
            .push_req_i   ( fwd_req[p]    ),
            .pop_i        ( pop[p]        ),
            .head_valid_o ( head_valid[p] ),
            .head_o       ( head[p]       )
        );
    end

    ddr_load_arbiter ddr_load_arbiter_i (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .head_valid_i    ( head_valid      ),
        .head_i          ( head            ),
        .pop_o           ( pop             ),
        .ddr_req_valid_o ( ddr_req_valid_o ),
        .ddr_req_addr_o  ( ddr_req_addr_o  ),
        .ddr_req_instr_o ( ddr_req_instr_o ),
        .ddr_rsp_valid_i ( ddr_rsp_valid_i ),
        .ddr_rsp_data_i  ( ddr_rsp_data_i  ),
        .rsp_valid_o     ( rsp_valid_o     ),
        .rsp_data_o      ( rsp_data_o      ),
        .rsp_err_o       ( rsp_err_o       )
    );

endmodule : mem_complex

/* ddr_load_arbiter.sv */
module ddr_load_arbiter import mem_map_pkg::*, link_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      head_valid_i [NUM_PORTS],
    input  port_req_t head_i       [NUM_PORTS],
    output logic      pop_o        [NUM_PORTS],

    output logic      ddr_req_valid_o,
    output addr_t     ddr_req_addr_o,
    output logic      ddr_req_instr_o,
    input  logic      ddr_rsp_valid_i,
    input  data_t     ddr_rsp_data_i,

    output logic      rsp_valid_o [NUM_PORTS],
    output data_t     rsp_data_o  [NUM_PORTS],
    output logic      rsp_err_o   [NUM_PORTS]
);

    localparam int CRED_W = $clog2(DDR_CREDITS + 1);

    logic [CRED_W-1:0] ddr_credits;  // free slots in the response buffer
    logic              win_valid;
    port_id_t          win_port;
    port_req_t         win_req;
    logic              take_head;
    logic              ddr_issue;
    logic              tag_empty;
    load_tag_t         tag_head;
    logic              buf_empty;
    data_t             buf_head;
    logic              deliver;
    logic              credit_ret;

    // ==================================================
    // request side
    // ==================================================

    always_comb begin
        win_valid = 1'b0;
        win_port  = PORT_INSTR;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (head_valid_i[p]) begin  // a higher port overrides a lower one
                win_valid = 1'b1;
                win_port  = port_id_t'(p);
            end
        end
    end

    assign win_req   = head_i[win_port];
    assign take_head = win_valid & (win_req.err | (ddr_credits != '0));
    assign ddr_issue = take_head & ~win_req.err;  // error heads never reach DDR

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            pop_o[p] = take_head && (win_port == port_id_t'(p));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) ddr_req_valid_o <= 1'b0;
        else ddr_req_valid_o <= ddr_issue;
    end

    always_ff @(posedge clk_i) begin
        if (ddr_issue) begin
            ddr_req_addr_o  <= win_req.addr;
            ddr_req_instr_o <= (win_port == PORT_INSTR);
        end
    end

    // every popped head leaves a tag so responses can be matched in order
    credit_fifo #(.payload_t(load_tag_t), .DEPTH(TAG_DEPTH)) tag_fifo_i (
        .clk_i       ( clk_i                      ),
        .rst_n_i     ( rst_n_i                    ),
        .push_i      ( take_head                  ),
        .push_data_i ( '{win_port, win_req.err}   ),
        .pop_i       ( deliver                    ),
        .empty_o     ( tag_empty                  ),
        .head_o      ( tag_head                   )
    );

    // ==================================================
    // response side
    // ==================================================

    credit_fifo #(.payload_t(data_t), .DEPTH(DDR_CREDITS)) rsp_buffer_i (
        .clk_i       ( clk_i           ),
        .rst_n_i     ( rst_n_i         ),
        .push_i      ( ddr_rsp_valid_i ),
        .push_data_i ( ddr_rsp_data_i  ),
        .pop_i       ( credit_ret      ),
        .empty_o     ( buf_empty       ),
        .head_o      ( buf_head        )
    );

    // an error tag goes out at once, a good one waits for its DDR data
    assign deliver    = ~tag_empty & (tag_head.err | ~buf_empty);
    assign credit_ret = deliver & ~tag_head.err;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ddr_credits <= CRED_W'(DDR_CREDITS);
        end else if (ddr_issue && !credit_ret) begin
            ddr_credits <= ddr_credits - 1'b1;
        end else if (!ddr_issue && credit_ret) begin
            ddr_credits <= ddr_credits + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n_i) rsp_valid_o[p] <= 1'b0;
            else rsp_valid_o[p] <= deliver && (tag_head.port == port_id_t'(p));
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (deliver && (tag_head.port == port_id_t'(p))) begin
                rsp_data_o[p] <= tag_head.err ? '0 : buf_head;
                rsp_err_o[p]  <= tag_head.err;
            end
        end
    end

endmodule : ddr_load_arbiter

/* load_port.sv */
module load_port import link_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // decoded request from the region decoder
    input  logic      push_i,
    input  port_req_t push_req_i,

    // head of the queue as seen by the arbiter
    input  logic      pop_i,
    output logic      head_valid_o,
    output port_req_t head_o
);

    logic queue_empty;
    logic queue_pop;

    // the requester never sends more than QUEUE_DEPTH loads without a response,
    // so the queue cannot fill up and no ready goes back to the decoder

    assign queue_pop = pop_i & ~queue_empty;  // a stray pop leaves the pointers alone

    credit_fifo #(
        .payload_t ( port_req_t  ),
        .DEPTH     ( QUEUE_DEPTH )
    ) req_queue_i (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .push_i      ( push_i      ),
        .push_data_i ( push_req_i  ),
        .pop_i       ( queue_pop   ),
        .empty_o     ( queue_empty ),
        .head_o      ( head_o      )
    );

    // occupancy is registered inside the queue, so the head shows up
    // in the cycle after the push
    assign head_valid_o = ~queue_empty;

endmodule : load_port

/* region_decoder.sv */
module region_decoder import mem_map_pkg::*, link_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // raw requests from the two requesters
    input  logic      req_valid_i [NUM_PORTS],
    input  addr_t     req_addr_i  [NUM_PORTS],

    // decoded requests towards the port queues
    output logic      fwd_valid_o [NUM_PORTS],
    output port_req_t fwd_req_o   [NUM_PORTS]
);

    // anything outside user memory turns into an error entry with a zero address
    function automatic port_req_t decode(input addr_t addr);
        port_req_t req;
        req.err  = (addr < USER_MEM_START) || (addr >= USER_MEM_END);
        req.addr = req.err ? '0 : addr - USER_MEM_START;
        return req;
    endfunction

    // ==================================================
    // one register stage per port
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                fwd_valid_o[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                fwd_valid_o[p] <= req_valid_i[p];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_valid_i[p]) begin
                fwd_req_o[p] <= decode(req_addr_i[p]);  // DDR offset or error
            end
        end
    end

endmodule : region_decoder

/* credit_fifo.sv */
module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     empty_o,
    output payload_t head_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // pointers wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= next_ptr(wr_ptr);
            if (pop_i) rd_ptr <= next_ptr(rd_ptr);

            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (!push_i && pop_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) mem[wr_ptr] <= push_data_i;  // the sender holds a credit so a slot is free
    end

    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];  // only meaningful while empty_o is low

endmodule : credit_fifo

/* link_pkg.sv */
package link_pkg;

    import mem_map_pkg::*;

    // ==================================================
    // requester and DDR channel sizing
    // ==================================================

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] data_t;

    localparam int NUM_PORTS = 2;

    typedef logic port_id_t;

    localparam port_id_t PORT_INSTR = 1'b0;  // instruction fetch
    localparam port_id_t PORT_DATA  = 1'b1;  // data loads, wins on a tie

    localparam int QUEUE_DEPTH = 4;  // credits each requester starts with
    localparam int DDR_CREDITS = 4;  // loads allowed in flight on DDR
    localparam int TAG_DEPTH   = NUM_PORTS * QUEUE_DEPTH;

    // one pending load as it sits in a port queue
    typedef struct packed {
        addr_t addr;  // already rebased to a DDR offset
        logic  err;
    } port_req_t;

    // remembers where a response must go once it comes back
    typedef struct packed {
        port_id_t port;
        logic     err;
    } load_tag_t;

endpackage : link_pkg

/* mem_map_pkg.sv */
package mem_map_pkg;

    // ==================================================
    // processor address map as seen by the load channel
    // ==================================================

    localparam int ADDR_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;

    // user memory is the only region backed by DDR
    localparam addr_t USER_MEM_START = 32'h0001_0000;
    localparam addr_t USER_MEM_END   = 32'h0011_0000;  // first byte past the region

    // everything below USER_MEM_START belongs to the boot ROM and
    // the IO window, neither of which is reachable through this path

endpackage : mem_map_pkg
